// File: Bender.yml
package:
  name: lsu

sources:
  - rtl/lsu_pkg.sv
  - rtl/lsu_store_align.sv
  - rtl/lsu_load_align.sv
  - rtl/lsu_data_ram.sv
  - rtl/lsu_ctrl_regs.sv
  - rtl/lsu_top.sv
  - target: test
    files:
      - tb/lsu_chk.sv
      - tb/lsu_tb.sv

// File: filelist.f
rtl/lsu_pkg.sv
rtl/lsu_store_align.sv
rtl/lsu_load_align.sv
rtl/lsu_data_ram.sv
rtl/lsu_ctrl_regs.sv
rtl/lsu_top.sv
tb/lsu_chk.sv
tb/lsu_tb.sv

// File: rtl/lsu_ctrl_regs.sv
/* lsu control and status registers */

`timescale 1ns/1ps
`default_nettype none

module lsu_ctrl_regs
  import lsu_pkg::*;
(
  input  logic     clk,
  input  logic     arst_n,
  input  lsu_req_t req,
  input  cfg_req_t cfg,
  output logic     access_ok,
  output logic     fault,
  output word_t    cfg_rdata
);

  logic  check_en_q;
  word_t stores_q;
  word_t loads_q;
  word_t faults_q;
  logic  is_byte;
  logic  is_half;
  logic  aligned;
  logic  bad_access;

  // ----------------------------------------
  // alignment check
  // ----------------------------------------
  // codes other than byte or half count as word
  assign is_byte = req.write ? (req.funct3 == F3_SB)
                             : (req.funct3 == F3_LB) || (req.funct3 == F3_LBU);
  assign is_half = req.write ? (req.funct3 == F3_SH)
                             : (req.funct3 == F3_LH) || (req.funct3 == F3_LHU);

  assign aligned = is_byte ||
                   (is_half && !req.addr[0]) ||
                   (req.addr[1:0] == 2'b00);

  assign access_ok  = req.valid && (!check_en_q || aligned);
  assign bad_access = req.valid && check_en_q && !aligned;

  // ----------------------------------------
  // registers and counters
  // ----------------------------------------
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      check_en_q <= 1'b1;
      fault      <= 1'b0;
      stores_q   <= '0;
      loads_q    <= '0;
      faults_q   <= '0;
    end else begin
      fault <= bad_access;
      if (access_ok && req.write) stores_q <= stores_q + 32'd1;
      if (access_ok && !req.write) loads_q <= loads_q + 32'd1;
      if (bad_access) faults_q <= faults_q + 32'd1;
      // a cfg clear overrides a same-cycle count
      if (cfg.we) begin
        case (cfg.addr)
          REG_CTRL:   check_en_q <= cfg.wdata[0];
          REG_STORES: stores_q   <= '0;
          REG_LOADS:  loads_q    <= '0;
          default:    faults_q   <= '0;
        endcase
      end
    end
  end

  always_comb begin
    case (cfg.addr)
      REG_CTRL:   cfg_rdata = {31'h0, check_en_q};
      REG_STORES: cfg_rdata = stores_q;
      REG_LOADS:  cfg_rdata = loads_q;
      default:    cfg_rdata = faults_q;
    endcase
  end

endmodule

`default_nettype wire

// File: rtl/lsu_data_ram.sv
/* data ram, byte lanes */

`timescale 1ns/1ps
`default_nettype none

module lsu_data_ram
  import lsu_pkg::*;
#(
  parameter int RAM_AW = 8
) (
  input  logic              clk,
  input  logic              we,
  input  strobe_t           be,
  input  logic [RAM_AW-1:0] waddr,
  input  logic [RAM_AW-1:0] raddr,
  input  word_t             wdata,
  input  logic              re,
  output word_t             rdata
);

  localparam int DEPTH = 1 << RAM_AW;

  word_t mem [DEPTH];

  // ----------------------------------------
  // write port
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (we) begin
      for (int i = 0; i < 4; i++) begin
        if (be[i]) begin
          mem[waddr][8*i +: 8] <= wdata[8*i +: 8];
        end
      end
    end
  end

  // ----------------------------------------
  // read port
  // ----------------------------------------
  // holds the last read word while re is low
  always_ff @(posedge clk) begin
    if (re) begin
      rdata <= mem[raddr];
    end
  end

endmodule

`default_nettype wire

// File: rtl/lsu_load_align.sv
/* load extract and extend */

`timescale 1ns/1ps
`default_nettype none

module lsu_load_align
  import lsu_pkg::*;
(
  input  logic       clk,
  input  logic       arst_n,
  input  logic       load_go,
  input  funct3_t    funct3,
  input  logic [1:0] addr_lo,
  input  word_t      ram_rdata,
  output word_t      rdata,
  output logic       rdata_valid
);

  load_info_t  info_q;
  logic        pend_q;
  logic [7:0]  sel_byte;
  logic [15:0] sel_half;
  word_t       ext_data;

  // stage 1, alongside the ram read
  always_ff @(posedge clk) begin
    if (load_go) begin
      info_q.funct3 <= funct3;
      info_q.offset <= addr_lo;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pend_q      <= 1'b0;
      rdata_valid <= 1'b0;
    end else begin
      pend_q      <= load_go;
      rdata_valid <= pend_q;
    end
  end

  always_comb begin
    case (info_q.offset)
      2'b00: sel_byte = ram_rdata[7:0];
      2'b01: sel_byte = ram_rdata[15:8];
      2'b10: sel_byte = ram_rdata[23:16];
      default: sel_byte = ram_rdata[31:24];
    endcase
    sel_half = info_q.offset[1] ? ram_rdata[31:16] : ram_rdata[15:0];
  end

  always_comb begin
    case (info_q.funct3)
      F3_LB:  ext_data = {{24{sel_byte[7]}}, sel_byte};
      F3_LBU: ext_data = {24'h0, sel_byte};
      F3_LH:  ext_data = {{16{sel_half[15]}}, sel_half};
      F3_LHU: ext_data = {16'h0, sel_half};
      F3_LW:  ext_data = ram_rdata;
      default: ext_data = ram_rdata;
    endcase
  end

  // stage 2, output register
  always_ff @(posedge clk) begin
    if (pend_q) begin
      rdata <= ext_data;
    end
  end

endmodule

`default_nettype wire

// File: rtl/lsu_pkg.sv
/* lsu shared definitions */

`default_nettype none

package lsu_pkg;

  // ----------------------------------------
  // base types
  // ----------------------------------------
  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;
  typedef logic [3:0]  strobe_t;
  typedef logic [2:0]  funct3_t;
  typedef logic [1:0]  cfg_addr_t;

  // riscv funct3 for loads and stores
  localparam funct3_t F3_SB  = 3'b000;
  localparam funct3_t F3_SH  = 3'b001;
  localparam funct3_t F3_SW  = 3'b010;
  localparam funct3_t F3_LB  = 3'b000;
  localparam funct3_t F3_LH  = 3'b001;
  localparam funct3_t F3_LW  = 3'b010;
  localparam funct3_t F3_LBU = 3'b100;
  localparam funct3_t F3_LHU = 3'b101;

  // register map, bit 0 of ctrl is check_en
  localparam cfg_addr_t REG_CTRL   = 2'd0;
  localparam cfg_addr_t REG_STORES = 2'd1;
  localparam cfg_addr_t REG_LOADS  = 2'd2;
  localparam cfg_addr_t REG_FAULTS = 2'd3;

  // ----------------------------------------
  // bundles
  // ----------------------------------------
  typedef struct packed {
    logic    valid;
    logic    write;
    funct3_t funct3;
    addr_t   addr;
    word_t   wdata;
  } lsu_req_t;

  typedef struct packed {
    logic      we;
    cfg_addr_t addr;
    word_t     wdata;
  } cfg_req_t;

  // what the load aligner needs one cycle later
  typedef struct packed {
    funct3_t    funct3;
    logic [1:0] offset;
  } load_info_t;

endpackage

`default_nettype wire

// File: rtl/lsu_store_align.sv
/* store lane alignment */

`timescale 1ns/1ps
`default_nettype none

module lsu_store_align
  import lsu_pkg::*;
(
  input  logic       store_go,
  input  funct3_t    funct3,
  input  logic [1:0] addr_lo,
  input  word_t      wdata,
  output word_t      wdata_aligned,
  output strobe_t    be
);

  word_t   byte_data;
  word_t   half_data;
  strobe_t byte_be;
  strobe_t half_be;
  strobe_t raw_be;

  // byte lane picked by both low address bits
  always_comb begin
    case (addr_lo)
      2'b00: byte_data = {24'h0, wdata[7:0]};
      2'b01: byte_data = {16'h0, wdata[7:0], 8'h0};
      2'b10: byte_data = {8'h0, wdata[7:0], 16'h0};
      default: byte_data = {wdata[7:0], 24'h0};
    endcase
    byte_be = strobe_t'(4'b0001 << addr_lo);
  end

  // half lane picked by addr bit 1 only
  always_comb begin
    if (addr_lo[1]) begin
      half_data = {wdata[15:0], 16'h0};
      half_be   = 4'b1100;
    end else begin
      half_data = {16'h0, wdata[15:0]};
      half_be   = 4'b0011;
    end
  end

  always_comb begin
    case (funct3)
      F3_SB: begin
        wdata_aligned = byte_data;
        raw_be        = byte_be;
      end
      F3_SH: begin
        wdata_aligned = half_data;
        raw_be        = half_be;
      end
      F3_SW: begin
        wdata_aligned = wdata;
        raw_be        = 4'b1111;
      end
      default: begin
        wdata_aligned = wdata;
        raw_be        = 4'b1111;
      end
    endcase
  end

  assign be = raw_be & {4{store_go}};

endmodule

`default_nettype wire

// File: rtl/lsu_top.sv
/* lsu data path top */

`timescale 1ns/1ps
`default_nettype none

module lsu_top
  import lsu_pkg::*;
#(
  parameter int RAM_AW = 8
) (
  input  logic     clk,
  input  logic     arst_n,
  input  lsu_req_t req,
  input  cfg_req_t cfg,
  output word_t    rdata,
  output logic     rdata_valid,
  output logic     fault,
  output word_t    cfg_rdata
);

  logic              access_ok;
  logic              store_go;
  logic              load_go;
  strobe_t           be;
  word_t             wdata_aligned;
  word_t             ram_rdata;
  logic [RAM_AW-1:0] ram_addr;

  // ----------------------------------------
  // request steering
  // ----------------------------------------
  lsu_ctrl_regs i_lsu_ctrl_regs (
    .clk       (clk),
    .arst_n    (arst_n),
    .req       (req),
    .cfg       (cfg),
    .access_ok (access_ok),
    .fault     (fault),
    .cfg_rdata (cfg_rdata)
  );

  assign store_go = access_ok && req.write;
  assign load_go  = access_ok && !req.write;

  // upper address bits wrap
  assign ram_addr = req.addr[RAM_AW+1:2];

  // ----------------------------------------
  // store side
  // ----------------------------------------
  lsu_store_align i_lsu_store_align (
    .store_go      (store_go),
    .funct3        (req.funct3),
    .addr_lo       (req.addr[1:0]),
    .wdata         (req.wdata),
    .wdata_aligned (wdata_aligned),
    .be            (be)
  );

  lsu_data_ram #(
    .RAM_AW (RAM_AW)
  ) i_lsu_data_ram (
    .clk   (clk),
    .we    (|be),
    .be    (be),
    .waddr (ram_addr),
    .raddr (ram_addr),
    .wdata (wdata_aligned),
    .re    (load_go),
    .rdata (ram_rdata)
  );

  // ----------------------------------------
  // load side
  // ----------------------------------------
  lsu_load_align i_lsu_load_align (
    .clk         (clk),
    .arst_n      (arst_n),
    .load_go     (load_go),
    .funct3      (req.funct3),
    .addr_lo     (req.addr[1:0]),
    .ram_rdata   (ram_rdata),
    .rdata       (rdata),
    .rdata_valid (rdata_valid)
  );

endmodule

`default_nettype wire

// File: tb/lsu_chk.sv
/* lsu output checks */

`timescale 1ns/1ps
`default_nettype none

module lsu_chk
  import lsu_pkg::*;
(
  input logic     clk,
  input logic     arst_n,
  input lsu_req_t req,
  input logic     access_ok,
  input logic     fault,
  input logic     rdata_valid
);

  int unsigned assert_fails = 0;

  a_no_overlap: assert property (@(posedge clk) disable iff (!arst_n)
    !(fault && rdata_valid))
    else begin
      assert_fails++;
      $error("fault and rdata_valid high in the same cycle");
    end

  // load data two edges after an accepted load
  a_rvalid_src: assert property (@(posedge clk) disable iff (!arst_n)
    rdata_valid |-> $past(access_ok && !req.write, 2))
    else begin
      assert_fails++;
      $error("rdata_valid without an accepted load");
    end

  a_fault_src: assert property (@(posedge clk) disable iff (!arst_n)
    fault |-> $past(req.valid))
    else begin
      assert_fails++;
      $error("fault without a valid request");
    end

  a_reset_quiet: assert property (@(posedge clk)
    !arst_n |-> (!fault && !rdata_valid))
    else begin
      assert_fails++;
      $error("fault or rdata_valid high during reset");
    end

endmodule

bind lsu_top lsu_chk i_lsu_chk (
  .clk         (clk),
  .arst_n      (arst_n),
  .req         (req),
  .access_ok   (access_ok),
  .fault       (fault),
  .rdata_valid (rdata_valid)
);

`default_nettype wire

// File: tb/lsu_stim.txt
# op f3 addr data expect fault   (S store, L load, W cfg write, R cfg read)
# all fields hex, for W and R the addr column is the register offset
R 0 00000000 00000000 00000001 0
R 0 00000001 00000000 00000000 0
R 0 00000002 00000000 00000000 0
R 0 00000003 00000000 00000000 0
S 2 00000010 11223344 00000000 0
L 2 00000010 00000000 11223344 0
S 0 00000010 000000aa 00000000 0
S 0 00000011 000000bb 00000000 0
S 0 00000012 000000cc 00000000 0
S 0 00000013 000000dd 00000000 0
L 2 00000010 00000000 ddccbbaa 0
S 1 00000012 0000beef 00000000 0
L 2 00000010 00000000 beefbbaa 0
L 0 00000010 00000000 ffffffaa 0
L 0 00000011 00000000 ffffffbb 0
L 0 00000012 00000000 ffffffef 0
L 0 00000013 00000000 ffffffbe 0
L 4 00000010 00000000 000000aa 0
L 4 00000011 00000000 000000bb 0
L 4 00000012 00000000 000000ef 0
L 4 00000013 00000000 000000be 0
L 1 00000010 00000000 ffffbbaa 0
L 1 00000012 00000000 ffffbeef 0
L 5 00000010 00000000 0000bbaa 0
L 5 00000012 00000000 0000beef 0
S 1 00000011 00001234 00000000 1
S 2 00000012 55667788 00000000 1
L 2 00000010 00000000 beefbbaa 0
W 0 00000000 00000000 00000000 0
S 1 00000011 00001234 00000000 0
L 2 00000010 00000000 beef1234 0
S 2 00000012 55667788 00000000 0
L 2 00000010 00000000 55667788 0
R 0 00000001 00000000 00000008 0
R 0 00000002 00000000 00000012 0
R 0 00000003 00000000 00000002 0
W 0 00000001 00000000 00000000 0
R 0 00000001 00000000 00000000 0
W 0 00000002 00000000 00000000 0
R 0 00000002 00000000 00000000 0
W 0 00000003 00000000 00000000 0
R 0 00000003 00000000 00000000 0

// File: tb/lsu_tb.sv
/* lsu testbench */

`timescale 1ns/1ps
`default_nettype none

module lsu_tb
  import lsu_pkg::*;
();

  typedef struct {
    string   op;
    funct3_t f3;
    addr_t   addr;
    word_t   data;
    word_t   exp_val;
    logic    exp_fault;
    int      line_no;
  } stim_rec_t;

  logic      clk;
  logic      arst_n;
  lsu_req_t  req;
  cfg_req_t  cfg;
  word_t     rdata;
  logic      rdata_valid;
  logic      fault;
  word_t     cfg_rdata;

  stim_rec_t stim_q[$];
  bit        stim_ready;
  int        value_errs;
  int        other_errs;
  int        checks;
  int        cur_line;
  int        total_errs;

  lsu_top #(
    .RAM_AW (8)
  ) i_lsu_top (
    .clk         (clk),
    .arst_n      (arst_n),
    .req         (req),
    .cfg         (cfg),
    .rdata       (rdata),
    .rdata_valid (rdata_valid),
    .fault       (fault),
    .cfg_rdata   (cfg_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ----------------------------------------
  // compare tasks
  // ----------------------------------------
  task automatic check_word(input string name, input word_t got, input word_t exp);
    checks++;
    if (got !== exp) begin
      value_errs++;
      $display("[FAIL] %s got 0x%08h expected 0x%08h (stim line %0d)",
               name, got, exp, cur_line);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      value_errs++;
      $display("[FAIL] %s got 0x%0h expected 0x%0h (stim line %0d)",
               name, got, exp, cur_line);
    end
  endtask

  // ----------------------------------------
  // stimulus file
  // ----------------------------------------
  task automatic load_stimulus();
    int        fd;
    int        n;
    int        line_no;
    string     line;
    string     op;
    funct3_t   f3;
    addr_t     a;
    word_t     d;
    word_t     e;
    logic      fb;
    stim_rec_t rec;
    fd = $fopen("tb/lsu_stim.txt", "r");
    if (fd == 0) begin
      $display("could not open the stimulus file tb/lsu_stim.txt");
      other_errs++;
      return;
    end
    line_no = 0;
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      line_no++;
      if (n <= 0 || line.len() == 0 || line[0] == "#") continue;
      n = $sscanf(line, "%s %h %h %h %h %h", op, f3, a, d, e, fb);
      if (n == 6) begin
        rec = '{op: op, f3: f3, addr: a, data: d, exp_val: e, exp_fault: fb, line_no: line_no};
        stim_q.push_back(rec);
      end else if (n > 0) begin
        $display("stimulus line %0d is malformed and was skipped", line_no);
        other_errs++;
      end
    end
    $fclose(fd);
    if (stim_q.size() == 0) begin
      $display("the stimulus file holds no records");
      other_errs++;
    end
  endtask

  // ----------------------------------------
  // operations
  // ----------------------------------------
  // one store or load, expects the fault pulse after the sampling edge
  task automatic run_access(input stim_rec_t s);
    logic is_load;
    logic seen;
    int   lat;
    is_load = (s.op == "L");
    req.valid  <= 1'b1;
    req.write  <= !is_load;
    req.funct3 <= s.f3;
    req.addr   <= s.addr;
    req.wdata  <= s.data;
    @(posedge clk);
    req.valid <= 1'b0;
    @(negedge clk);
    check_bit("fault", fault, s.exp_fault);
    check_bit("rdata_valid", rdata_valid, 1'b0);
    if (is_load && !s.exp_fault) begin
      seen = 1'b0;
      lat  = 0;
      while (!seen && lat < 4) begin
        @(negedge clk);
        lat++;
        seen = rdata_valid;
      end
      if (!seen) begin
        $display("load at 0x%08h never raised rdata_valid (stim line %0d)", s.addr, cur_line);
        other_errs++;
      end else begin
        if (lat != 1) begin
          $display("rdata_valid came %0d cycles late (stim line %0d)", lat - 1, cur_line);
          other_errs++;
        end
        check_word("rdata", rdata, s.exp_val);
      end
    end else if (is_load) begin
      @(negedge clk);
      check_bit("rdata_valid", rdata_valid, 1'b0);
    end
    @(posedge clk);
  endtask

  task automatic cfg_write(input stim_rec_t s);
    cfg.we    <= 1'b1;
    cfg.addr  <= s.addr[1:0];
    cfg.wdata <= s.data;
    @(posedge clk);
    cfg.we <= 1'b0;
  endtask

  task automatic cfg_read(input stim_rec_t s);
    cfg.addr <= s.addr[1:0];
    @(negedge clk);
    check_word("cfg_rdata", cfg_rdata, s.exp_val);
    check_bit("fault", fault, 1'b0);
    @(posedge clk);
  endtask

  initial begin
    arst_n     = 1'b0;
    req        = '0;
    cfg        = '0;
    value_errs = 0;
    other_errs = 0;
    checks     = 0;
    cur_line   = 0;
    load_stimulus();
    stim_ready = 1'b1;
    // outputs stay quiet while reset is held
    repeat (16) begin
      @(posedge clk);
      @(negedge clk);
      check_bit("fault", fault, 1'b0);
      check_bit("rdata_valid", rdata_valid, 1'b0);
    end
    @(posedge clk);
    arst_n <= 1'b1;
    @(posedge clk);
    foreach (stim_q[i]) begin
      cur_line = stim_q[i].line_no;
      case (stim_q[i].op)
        "S", "L": run_access(stim_q[i]);
        "W": cfg_write(stim_q[i]);
        "R": cfg_read(stim_q[i]);
        default: begin
          $display("unknown operation %s on stim line %0d", stim_q[i].op, cur_line);
          other_errs++;
        end
      endcase
    end
    repeat (4) @(negedge clk);
    total_errs = value_errs + other_errs + i_lsu_top.i_lsu_chk.assert_fails;
    $display("summary: %0d checks, %0d value errors, %0d other errors, %0d assertion failures",
             checks, value_errs, other_errs, i_lsu_top.i_lsu_chk.assert_fails);
    if (total_errs == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // watchdog sized from the stimulus length
  initial begin
    wait (stim_ready);
    repeat (stim_q.size() * 4 + 200) @(posedge clk);
    $display("watchdog expired after %0d cycles, the run did not finish",
             stim_q.size() * 4 + 200);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire
